/* verilog/tile_cfg.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compute tile build constants
//   Bus widths and number of masters
//   Data memory depth
//   Address range decoding of the slaves
//   Boot ROM size and contents base
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

// Classic Wishbone bus geometry
`define TILE_DATA_WIDTH       32
`define TILE_ADDR_WIDTH       32
`define TILE_SEL_WIDTH        4
`define TILE_NR_MASTERS       2

// Local data memory, in words
`define TILE_LMEM_WORDS       256

// Top address bits compared by the decoder
`define TILE_RANGE_WIDTH      4
`define TILE_DM_RANGE_MATCH   4'h0
`define TILE_BOOT_RANGE_MATCH 4'hf

// Boot ROM, word i reads as pattern plus i
`define TILE_BOOT_WORDS       16
`define TILE_BOOT_PATTERN     32'hB0070000

`endif

/* verilog/tile_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the compute tile bus
//   Data word, address and byte-select types
//   Decoded slave target and master index
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "tile_cfg.svh"

package tile_pkg;

   typedef logic [`TILE_DATA_WIDTH-1:0] word_t;   // One bus data word
   typedef logic [`TILE_ADDR_WIDTH-1:0] addr_t;   // Byte address
   typedef logic [`TILE_SEL_WIDTH-1:0]  sel_t;    // One bit per byte lane

   // Target picked by the address decoder
   typedef enum logic [1:0] {
      SLAVE_DM   = 2'd0,   // Local data memory
      SLAVE_BOOT = 2'd1,   // Boot ROM
      SLAVE_NONE = 2'd2    // Unmapped, bus answers with err
   } slave_e;

   typedef logic [$clog2(`TILE_NR_MASTERS)-1:0] master_idx_t;

endpackage

`default_nettype wire

/* verilog/tile_bus.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared classic bus of the compute tile
//   Round-robin arbiter for two masters, grant held for a whole cycle
//   Top-nibble address decoder with slave strobe steering
//   Error response for unmapped addresses
//   Response multiplexer back to the granted master
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "tile_cfg.svh"

module tile_bus (
   input  wire                     clk,
   input  wire                     reset_i,
   // Master 0
   input  wire                     m0_cyc_i,
   input  wire                     m0_stb_i,
   input  wire                     m0_we_i,
   input  wire tile_pkg::addr_t    m0_adr_i,
   input  wire tile_pkg::word_t    m0_dat_i,
   input  wire tile_pkg::sel_t     m0_sel_i,
   output logic                    m0_ack_o,
   output logic                    m0_err_o,
   output tile_pkg::word_t         m0_dat_o,
   // Master 1
   input  wire                     m1_cyc_i,
   input  wire                     m1_stb_i,
   input  wire                     m1_we_i,
   input  wire tile_pkg::addr_t    m1_adr_i,
   input  wire tile_pkg::word_t    m1_dat_i,
   input  wire tile_pkg::sel_t     m1_sel_i,
   output logic                    m1_ack_o,
   output logic                    m1_err_o,
   output tile_pkg::word_t         m1_dat_o,
   // Slave side
   output tile_pkg::addr_t         s_adr_o,
   output tile_pkg::word_t         s_dat_o,
   output logic                    s_we_o,
   output tile_pkg::sel_t          s_sel_o,
   output logic                    dm_stb_o,
   output logic                    boot_stb_o,
   input  wire                     dm_ack_i,
   input  wire                     dm_err_i,
   input  wire tile_pkg::word_t    dm_dat_i,
   input  wire                     boot_ack_i,
   input  wire                     boot_err_i,
   input  wire tile_pkg::word_t    boot_dat_i
);

   logic                  req0, req1;
   logic                  own_cyc, own_stb, active;
   logic                  grant_vld_q;
   tile_pkg::master_idx_t grant_idx_q;
   tile_pkg::master_idx_t rr_prio_q;     // Master favored on a tie
   tile_pkg::master_idx_t next_idx;
   tile_pkg::slave_e      dec_slave;
   logic                  bus_err_q;
   logic                  resp_ack, resp_err;
   tile_pkg::word_t       resp_dat;

   assign req0 = m0_cyc_i & m0_stb_i;
   assign req1 = m1_cyc_i & m1_stb_i;

   always_comb begin
      if (req0 && req1) next_idx = rr_prio_q;
      else if (req1)    next_idx = tile_pkg::master_idx_t'(1);
      else              next_idx = tile_pkg::master_idx_t'(0);
   end

   // Grant is kept until the owner lets go of cyc
   always_ff @(posedge clk) begin
      if (reset_i) begin
         grant_vld_q <= 1'b0;
         grant_idx_q <= '0;
         rr_prio_q   <= '0;
      end else if (!grant_vld_q) begin
         if (req0 || req1) begin
            grant_vld_q <= 1'b1;
            grant_idx_q <= next_idx;
            rr_prio_q   <= ~next_idx;   // Other master wins the next tie
         end
      end else if (!own_cyc) begin
         grant_vld_q <= 1'b0;
      end
   end

   // Shared request signals follow the grant
   assign own_cyc = grant_idx_q[0] ? m1_cyc_i : m0_cyc_i;
   assign own_stb = grant_idx_q[0] ? m1_stb_i : m0_stb_i;
   assign s_adr_o = grant_idx_q[0] ? m1_adr_i : m0_adr_i;
   assign s_dat_o = grant_idx_q[0] ? m1_dat_i : m0_dat_i;
   assign s_we_o  = grant_idx_q[0] ? m1_we_i  : m0_we_i;
   assign s_sel_o = grant_idx_q[0] ? m1_sel_i : m0_sel_i;
   assign active  = grant_vld_q & own_cyc & own_stb;

   always_comb begin
      unique case (s_adr_o[`TILE_ADDR_WIDTH-1 -: `TILE_RANGE_WIDTH])
         `TILE_DM_RANGE_MATCH:   dec_slave = tile_pkg::SLAVE_DM;
         `TILE_BOOT_RANGE_MATCH: dec_slave = tile_pkg::SLAVE_BOOT;
         default:                dec_slave = tile_pkg::SLAVE_NONE;
      endcase
   end

   assign dm_stb_o   = active && (dec_slave == tile_pkg::SLAVE_DM);
   assign boot_stb_o = active && (dec_slave == tile_pkg::SLAVE_BOOT);

   // Unmapped access, one-cycle err with slave latency
   always_ff @(posedge clk) begin
      if (reset_i) bus_err_q <= 1'b0;
      else         bus_err_q <= active && (dec_slave == tile_pkg::SLAVE_NONE) && !bus_err_q;
   end

   assign resp_ack = dm_ack_i | boot_ack_i;
   assign resp_err = dm_err_i | boot_err_i | bus_err_q;
   assign resp_dat = (dec_slave == tile_pkg::SLAVE_BOOT) ? boot_dat_i : dm_dat_i;

   assign m0_ack_o = grant_vld_q && (grant_idx_q == 1'b0) && resp_ack;
   assign m0_err_o = grant_vld_q && (grant_idx_q == 1'b0) && resp_err;
   assign m0_dat_o = (grant_idx_q == 1'b0) ? resp_dat : '0;
   assign m1_ack_o = grant_vld_q && (grant_idx_q == 1'b1) && resp_ack;
   assign m1_err_o = grant_vld_q && (grant_idx_q == 1'b1) && resp_err;
   assign m1_dat_o = (grant_idx_q == 1'b1) ? resp_dat : '0;

endmodule

`default_nettype wire

/* verilog/tile_sram.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Local data memory slave of the compute tile
//   Single-port word memory with byte-lane writes
//   Registered one-cycle ack, read data valid in the ack cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "tile_cfg.svh"

module tile_sram (
   input  wire                  clk,
   input  wire                  reset_i,
   input  wire                  stb_i,
   input  wire                  we_i,
   input  wire tile_pkg::addr_t adr_i,
   input  wire tile_pkg::word_t dat_i,
   input  wire tile_pkg::sel_t  sel_i,
   output logic                 ack_o,
   output logic                 err_o,
   output tile_pkg::word_t      dat_o
);

   localparam int unsigned AW  = $clog2(`TILE_LMEM_WORDS);
   localparam int unsigned OFS = $clog2(`TILE_SEL_WIDTH);   // Byte offset bits

   tile_pkg::word_t mem_q [`TILE_LMEM_WORDS];
   tile_pkg::word_t dat_q;
   logic [AW-1:0]   idx;
   logic            ack_q;
   logic            req;

   assign idx = adr_i[OFS +: AW];   // Upper address bits wrap
   assign req = stb_i & ~ack_q;     // No second ack on a held strobe

   always_ff @(posedge clk) begin
      if (reset_i) ack_q <= 1'b0;
      else         ack_q <= req;
   end

   always_ff @(posedge clk) begin
      if (req) begin
         dat_q <= mem_q[idx];
         if (we_i) begin
            for (int b = 0; b < `TILE_SEL_WIDTH; b++) begin
               if (sel_i[b]) mem_q[idx][8*b +: 8] <= dat_i[8*b +: 8];
            end
         end
      end
   end

   assign ack_o = ack_q;
   assign err_o = 1'b0;   // Every mapped word is writable
   assign dat_o = dat_q;

endmodule

`default_nettype wire

/* verilog/tile_bootrom.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Boot ROM slave of the compute tile
//   Fixed contents, word i is the boot pattern plus i
//   Reads ack after one cycle, writes answer with err
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "tile_cfg.svh"

module tile_bootrom (
   input  wire                  clk,
   input  wire                  reset_i,
   input  wire                  stb_i,
   input  wire                  we_i,
   input  wire tile_pkg::addr_t adr_i,
   output logic                 ack_o,
   output logic                 err_o,
   output tile_pkg::word_t      dat_o
);

   localparam int unsigned AW  = $clog2(`TILE_BOOT_WORDS);
   localparam int unsigned OFS = $clog2(`TILE_SEL_WIDTH);

   logic [AW-1:0]   idx;
   logic            ack_q, err_q;
   logic            req;
   tile_pkg::word_t dat_q;

   assign idx = adr_i[OFS +: AW];            // Index modulo ROM depth
   assign req = stb_i & ~(ack_q | err_q);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= req & ~we_i;
         err_q <= req & we_i;   // ROM is never written
      end
   end

   // Contents generated from the index
   always_ff @(posedge clk) begin
      if (req) dat_q <= `TILE_BOOT_PATTERN + tile_pkg::word_t'(idx);
   end

   assign ack_o = ack_q;
   assign err_o = err_q;
   assign dat_o = dat_q;

endmodule

`default_nettype wire

/* verilog/compute_tile.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compute tile top level
//   Two external bus masters on the shared tile bus
//   Data memory and boot ROM slaves behind the decoder
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module compute_tile (
   input  wire                  clk,
   input  wire                  reset_i,
   input  wire                  m0_cyc_i,
   input  wire                  m0_stb_i,
   input  wire                  m0_we_i,
   input  wire tile_pkg::addr_t m0_adr_i,
   input  wire tile_pkg::word_t m0_dat_i,
   input  wire tile_pkg::sel_t  m0_sel_i,
   output logic                 m0_ack_o,
   output logic                 m0_err_o,
   output tile_pkg::word_t      m0_dat_o,
   input  wire                  m1_cyc_i,
   input  wire                  m1_stb_i,
   input  wire                  m1_we_i,
   input  wire tile_pkg::addr_t m1_adr_i,
   input  wire tile_pkg::word_t m1_dat_i,
   input  wire tile_pkg::sel_t  m1_sel_i,
   output logic                 m1_ack_o,
   output logic                 m1_err_o,
   output tile_pkg::word_t      m1_dat_o
);

   tile_pkg::addr_t s_adr;   // Shared request of the granted master
   tile_pkg::word_t s_dat;
   logic            s_we;
   tile_pkg::sel_t  s_sel;
   logic            dm_stb, dm_ack, dm_err;
   tile_pkg::word_t dm_dat;
   logic            boot_stb, boot_ack, boot_err;
   tile_pkg::word_t boot_dat;

   tile_bus u_bus (
      .clk        (clk),
      .reset_i    (reset_i),
      .m0_cyc_i   (m0_cyc_i),
      .m0_stb_i   (m0_stb_i),
      .m0_we_i    (m0_we_i),
      .m0_adr_i   (m0_adr_i),
      .m0_dat_i   (m0_dat_i),
      .m0_sel_i   (m0_sel_i),
      .m0_ack_o   (m0_ack_o),
      .m0_err_o   (m0_err_o),
      .m0_dat_o   (m0_dat_o),
      .m1_cyc_i   (m1_cyc_i),
      .m1_stb_i   (m1_stb_i),
      .m1_we_i    (m1_we_i),
      .m1_adr_i   (m1_adr_i),
      .m1_dat_i   (m1_dat_i),
      .m1_sel_i   (m1_sel_i),
      .m1_ack_o   (m1_ack_o),
      .m1_err_o   (m1_err_o),
      .m1_dat_o   (m1_dat_o),
      .s_adr_o    (s_adr),
      .s_dat_o    (s_dat),
      .s_we_o     (s_we),
      .s_sel_o    (s_sel),
      .dm_stb_o   (dm_stb),
      .boot_stb_o (boot_stb),
      .dm_ack_i   (dm_ack),
      .dm_err_i   (dm_err),
      .dm_dat_i   (dm_dat),
      .boot_ack_i (boot_ack),
      .boot_err_i (boot_err),
      .boot_dat_i (boot_dat)
   );

   tile_sram u_sram (
      .clk     (clk),
      .reset_i (reset_i),
      .stb_i   (dm_stb),
      .we_i    (s_we),
      .adr_i   (s_adr),
      .dat_i   (s_dat),
      .sel_i   (s_sel),
      .ack_o   (dm_ack),
      .err_o   (dm_err),
      .dat_o   (dm_dat)
   );

   // ROM ignores write data and lanes
   tile_bootrom u_bootrom (
      .clk     (clk),
      .reset_i (reset_i),
      .stb_i   (boot_stb),
      .we_i    (s_we),
      .adr_i   (s_adr),
      .ack_o   (boot_ack),
      .err_o   (boot_err),
      .dat_o   (boot_dat)
   );

endmodule

`default_nettype wire

/* verification/tb_clkgen.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock source
//   Free-running clock, starts low, default period 4 ns
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
   parameter real PERIOD_NS = 4.0
) (
   output logic clk_o
);

   initial clk_o = 1'b0;

   always #(PERIOD_NS / 2.0) clk_o = ~clk_o;   // Half period per phase

endmodule

`default_nettype wire

/* verification/compute_tile_assertions.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus handshake assertions for the compute tile
//   Ack and err exclusive per master
//   At most one master answered per cycle
//   Responses only to a strobing master, none during reset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module compute_tile_assertions (
   input wire clk,
   input wire reset_i,
   input wire m0_stb_i,
   input wire m1_stb_i,
   input wire m0_ack_o,
   input wire m0_err_o,
   input wire m1_ack_o,
   input wire m1_err_o
);

   wire m0_resp = m0_ack_o | m0_err_o;
   wire m1_resp = m1_ack_o | m1_err_o;

   a_m0_ack_err_excl: assert property (@(posedge clk) disable iff (reset_i)
      !(m0_ack_o && m0_err_o)) else $error("m0 ack and err high together");

   a_m1_ack_err_excl: assert property (@(posedge clk) disable iff (reset_i)
      !(m1_ack_o && m1_err_o)) else $error("m1 ack and err high together");

   a_one_master_resp: assert property (@(posedge clk) disable iff (reset_i)
      !(m0_resp && m1_resp)) else $error("both masters answered in one cycle");

   a_m0_resp_stb: assert property (@(posedge clk) disable iff (reset_i)
      m0_resp |-> m0_stb_i) else $error("m0 answered without stb");

   a_m1_resp_stb: assert property (@(posedge clk) disable iff (reset_i)
      m1_resp |-> m1_stb_i) else $error("m1 answered without stb");

   // Registers are settled one edge into reset
   a_quiet_in_reset: assert property (@(posedge clk)
      (reset_i && $past(reset_i)) |-> !(m0_resp || m1_resp))
      else $error("response during reset");

endmodule

bind compute_tile compute_tile_assertions u_assertions (
   .clk      (clk),
   .reset_i  (reset_i),
   .m0_stb_i (m0_stb_i),
   .m1_stb_i (m1_stb_i),
   .m0_ack_o (m0_ack_o),
   .m0_err_o (m0_err_o),
   .m1_ack_o (m1_ack_o),
   .m1_err_o (m1_err_o)
);

`default_nettype wire

/* verification/compute_tile_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the compute tile
//   Table of bus accesses applied in a loop on two masters
//   Data memory model, boot ROM rule and arbitration order model
//   Watchdog and closing summary
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "tile_cfg.svh"

module compute_tile_tb;

   localparam int CLK_NS      = 4;
   localparam int NROWS       = 15;
   localparam int RESET_CYC   = 3;
   localparam int ACCESS_MAX  = 20;   // Cycles one access may take
   localparam int TIMEOUT_NS  = NROWS * 20 * CLK_NS + (RESET_CYC + 2) * CLK_NS;
   localparam int IDX_W       = $clog2(`TILE_LMEM_WORDS);
   localparam int ROM_W       = $clog2(`TILE_BOOT_WORDS);
   localparam int OFS         = $clog2(`TILE_SEL_WIDTH);

   // Master 2 runs both at once with m1 on adr_b
   typedef struct {
      int              master;
      bit              we;
      tile_pkg::addr_t adr;
      tile_pkg::addr_t adr_b;
      tile_pkg::sel_t  sel;
      bit              exp_err;
   } row_t;

   row_t rows [NROWS] = '{
      '{2, 1'b1, 32'h0000_0040, 32'h0000_0044, 4'hf, 1'b0},
      '{2, 1'b0, 32'h0000_0040, 32'h0000_0044, 4'hf, 1'b0},
      '{0, 1'b1, 32'h0000_0010, 32'h0,         4'hf, 1'b0},
      '{0, 1'b0, 32'h0000_0010, 32'h0,         4'hf, 1'b0},
      '{1, 1'b1, 32'h0000_0020, 32'h0,         4'hf, 1'b0},
      '{1, 1'b0, 32'h0000_0020, 32'h0,         4'hf, 1'b0},
      '{0, 1'b1, 32'h0000_0010, 32'h0,         4'h5, 1'b0},   // Partial write
      '{1, 1'b0, 32'h0000_0010, 32'h0,         4'hf, 1'b0},
      '{0, 1'b0, 32'hf000_0008, 32'h0,         4'hf, 1'b0},
      '{1, 1'b0, 32'hf000_007c, 32'h0,         4'hf, 1'b0},   // ROM index wraps
      '{0, 1'b1, 32'hf000_0004, 32'h0,         4'hf, 1'b1},
      '{1, 1'b0, 32'h3000_0000, 32'h0,         4'hf, 1'b1},
      '{0, 1'b1, 32'h8000_0010, 32'h0,         4'hf, 1'b1},
      '{0, 1'b0, 32'h0000_0010, 32'h0,         4'hf, 1'b0},
      '{2, 1'b0, 32'h0000_0020, 32'hf000_0004, 4'hf, 1'b0}
   };

   logic            clk;
   logic            reset_i;
   logic            m0_cyc_i, m0_stb_i, m0_we_i;
   tile_pkg::addr_t m0_adr_i;
   tile_pkg::word_t m0_dat_i;
   tile_pkg::sel_t  m0_sel_i;
   logic            m0_ack_o, m0_err_o;
   tile_pkg::word_t m0_dat_o;
   logic            m1_cyc_i, m1_stb_i, m1_we_i;
   tile_pkg::addr_t m1_adr_i;
   tile_pkg::word_t m1_dat_i;
   tile_pkg::sel_t  m1_sel_i;
   logic            m1_ack_o, m1_err_o;
   tile_pkg::word_t m1_dat_o;

   tile_pkg::word_t mem_model [`TILE_LMEM_WORDS];
   int              pass_cnt = 0;
   int              fail_cnt = 0;
   bit              row_ok;
   int              served_last = 1;   // So master 0 wins the first tie

   tb_clkgen #(.PERIOD_NS(CLK_NS)) u_clkgen (.clk_o(clk));

   compute_tile compute_tile_inst (.*);

   task automatic set_request(input int m, input bit on, input bit we,
                              input tile_pkg::addr_t adr, input tile_pkg::word_t dat,
                              input tile_pkg::sel_t sel);
      if (m == 0) begin
         m0_cyc_i = on;
         m0_stb_i = on;
         m0_we_i  = we;
         m0_adr_i = adr;
         m0_dat_i = dat;
         m0_sel_i = sel;
      end else begin
         m1_cyc_i = on;
         m1_stb_i = on;
         m1_we_i  = we;
         m1_adr_i = adr;
         m1_dat_i = dat;
         m1_sel_i = sel;
      end
   endtask

   // Runs from a falling edge until cyc is dropped
   task automatic run_access(input int m, input bit we, input tile_pkg::addr_t adr,
                             input tile_pkg::word_t dat, input tile_pkg::sel_t sel,
                             output bit ack, output bit err,
                             output tile_pkg::word_t rdat, output int lat);
      bit done;
      done = 1'b0;
      lat  = 0;
      ack  = 1'b0;
      err  = 1'b0;
      rdat = '0;
      set_request(m, 1'b1, we, adr, dat, sel);
      while (!done && lat < ACCESS_MAX) begin
         @(negedge clk);
         lat++;
         ack  = (m == 0) ? m0_ack_o : m1_ack_o;
         err  = (m == 0) ? m0_err_o : m1_err_o;
         rdat = (m == 0) ? m0_dat_o : m1_dat_o;
         done = ack | err;
      end
      if (!done) begin
         $display("master %0d got no response within %0d cycles", m, ACCESS_MAX);
         row_ok = 1'b0;
      end
      @(negedge clk);
      if (done && ((m == 0) ? (m0_ack_o | m0_err_o) : (m1_ack_o | m1_err_o))) begin
         $display("master %0d response lasted longer than one cycle", m);
         row_ok = 1'b0;
      end
      set_request(m, 1'b0, we, adr, dat, sel);
   endtask

   function automatic tile_pkg::word_t expected_read(input tile_pkg::addr_t adr);
      if (adr[31 -: 4] == `TILE_BOOT_RANGE_MATCH)
         return `TILE_BOOT_PATTERN + tile_pkg::word_t'(adr[OFS +: ROM_W]);
      return mem_model[adr[OFS +: IDX_W]];
   endfunction

   task automatic update_model(input tile_pkg::addr_t adr, input tile_pkg::word_t dat,
                               input tile_pkg::sel_t sel);
      for (int b = 0; b < `TILE_SEL_WIDTH; b++) begin
         if (sel[b]) mem_model[adr[OFS +: IDX_W]][8*b +: 8] = dat[8*b +: 8];
      end
   endtask

   task automatic check_resp(input int m, input bit we, input bit exp_err,
                             input tile_pkg::word_t exp_dat, input bit ack,
                             input bit err, input tile_pkg::word_t rdat);
      if (err !== exp_err) begin
         $display("FAIL m%0d_err_o exp %h got %h", m, exp_err, err);
         row_ok = 1'b0;
      end
      if (ack !== !exp_err) begin
         $display("FAIL m%0d_ack_o exp %h got %h", m, !exp_err, ack);
         row_ok = 1'b0;
      end
      if (!we && !exp_err && rdat !== exp_dat) begin
         $display("FAIL m%0d_dat_o exp %h got %h", m, exp_dat, rdat);
         row_ok = 1'b0;
      end
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("watchdog expired, the tests did not finish in time");
      $display("sim failed");
      $finish;
   end

   initial begin
      int unsigned     seed_val;
      tile_pkg::word_t d0, d1, e0, e1, r0, r1;
      bit              a0, a1, x0, x1;
      int              l0, l1, first;
      row_t            r;

      reset_i = 1'b1;
      set_request(0, 1'b0, 1'b0, '0, '0, '0);
      set_request(1, 1'b0, 1'b0, '0, '0, '0);
      seed_val = $urandom(32'h70f116f8);
      repeat (RESET_CYC) @(posedge clk);
      @(negedge clk);
      reset_i = 1'b0;
      @(negedge clk);

      for (int i = 0; i < NROWS; i++) begin
         r      = rows[i];
         row_ok = 1'b1;
         d0     = $urandom();
         d1     = $urandom();
         e0     = expected_read(r.adr);
         e1     = expected_read(r.adr_b);
         if (r.master == 2) begin
            fork
               run_access(0, r.we, r.adr, d0, r.sel, a0, x0, r0, l0);
               run_access(1, r.we, r.adr_b, d1, r.sel, a1, x1, r1, l1);
            join
            check_resp(0, r.we, r.exp_err, e0, a0, x0, r0);
            check_resp(1, r.we, r.exp_err, e1, a1, x1, r1);
            first = (served_last == 0) ? 1 : 0;   // Tie goes to the other master
            if (l0 == l1) begin
               $display("both masters answered in the same cycle");
               row_ok = 1'b0;
            end else if ((l0 < l1 ? 0 : 1) != first) begin
               $display("FAIL first_master exp %h got %h", first, (l0 < l1) ? 0 : 1);
               row_ok = 1'b0;
            end
            if (r.we && !r.exp_err) begin
               update_model(r.adr, d0, r.sel);
               update_model(r.adr_b, d1, r.sel);
            end
            served_last = 1 - first;   // Second master was served last
         end else begin
            run_access(r.master, r.we, r.adr, d0, r.sel, a0, x0, r0, l0);
            check_resp(r.master, r.we, r.exp_err, e0, a0, x0, r0);
            if (l0 != 2) begin
               $display("FAIL latency exp %h got %h", 2, l0);
               row_ok = 1'b0;
            end
            if (r.we && !r.exp_err) update_model(r.adr, d0, r.sel);
            served_last = r.master;
         end
         if (row_ok) begin
            pass_cnt++;
            $display("row %0d passed", i);
         end else begin
            fail_cnt++;
            $display("row %0d had errors", i);
         end
         @(negedge clk);   // One idle cycle between rows
      end

      $display("rows passed %0d, rows failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verilog
verilog/tile_pkg.sv
verilog/tile_bus.sv
verilog/tile_sram.sv
verilog/tile_bootrom.sv
verilog/compute_tile.sv
verification/tb_clkgen.sv
verification/compute_tile_assertions.sv
verification/compute_tile_tb.sv

/* Bender.yml */
package:
  name: compute_tile

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/tile_pkg.sv
      - verilog/tile_bus.sv
      - verilog/tile_sram.sv
      - verilog/tile_bootrom.sv
      - verilog/compute_tile.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/tb_clkgen.sv
      - verification/compute_tile_assertions.sv
      - verification/compute_tile_tb.sv
